// ==== hdl/core_shell_pkg.sv ====
/*
  Shared widths, register map, timing constants and types of the console shell.
  reset_hold_cycles and ff_tap_cycles are shortened for simulation; scale them
  up for a real 32 MHz system clock.
*/
package core_shell_pkg;

  ////////////////////////////////
  // widths
  ////////////////////////////////
  localparam int word_w   = 32;
  localparam int sample_w = 16;
  localparam int color_w  = 8;

  ////////////////////////////////
  // host register map
  ////////////////////////////////
  localparam logic [word_w-1:0] reg_reset_addr    = word_w'('h050);
  localparam logic [word_w-1:0] reg_mapper_addr   = word_w'('h200);
  localparam logic [word_w-1:0] reg_sys_type_addr = word_w'('h208);
  localparam logic [word_w-1:0] reg_ff_snd_addr   = word_w'('h20C);
  localparam logic [word_w-1:0] reg_gray_addr     = word_w'('h220);

  ////////////////////////////////
  // timing
  ////////////////////////////////
  localparam int reset_hold_cycles = 256;
  localparam int ff_tap_cycles     = 64;
  localparam int hsync_delay       = 7;

  // counter widths, sized so the load value fits
  localparam int reset_cnt_w = $clog2(reset_hold_cycles + 1);
  localparam int ff_cnt_w    = $clog2(ff_tap_cycles + 1);
  localparam int hs_cnt_w    = $clog2(hsync_delay + 1);

  // right shoulder (r1) in the controller key word
  localparam int ff_key_bit = 9;

  ////////////////////////////////
  // types
  ////////////////////////////////
  typedef struct packed {
    logic              wr;
    logic [word_w-1:0] addr;
    logic [word_w-1:0] data;
  } bridge_wr_t;

  // write data as a raw word or as the select field of a setting
  typedef union packed {
    logic [word_w-1:0] raw;
    struct packed {
      logic [word_w-4:0] unused;
      logic [2:0]        sel;
    } fields;
  } setting_word_u;

  typedef struct packed {
    logic [2:0] mapper_sel;
    logic [1:0] sys_type;
    logic       ff_snd_en;
    logic       gray_en;
  } core_settings_t;

  typedef struct packed {
    logic [sample_w-1:0] left;
    logic [sample_w-1:0] right;
  } stereo_t;

  typedef struct packed {
    logic [color_w-1:0] red;
    logic [color_w-1:0] green;
    logic [color_w-1:0] blue;
  } rgb_t;

  typedef struct packed {
    rgb_t rgb;
    logic hs;
    logic vs;
    logic hblank;
    logic vblank;
  } video_in_t;

  typedef struct packed {
    rgb_t rgb;
    logic de;
    logic hs;
    logic vs;
  } video_out_t;

endpackage

// ==== hdl/host_settings.sv ====
/*
  Write-only host settings bank. Writes are taken on every cycle the strobe is
  high; unknown addresses are ignored. Reset, mapper and system-type writes
  (re)start a core_reset pulse of reset_hold_cycles cycles.
*/
module host_settings (
  input  logic                           clk_sys,
  input  logic                           pll_core_locked,
  input  core_shell_pkg::bridge_wr_t     bridge,
  output core_shell_pkg::core_settings_t settings,
  output logic                           core_reset
);

  import core_shell_pkg::*;

  setting_word_u          wr_word;
  logic [reset_cnt_w-1:0] hold_cnt;

  assign wr_word = bridge.data;

  // pulse lasts while the counter is non-zero
  assign core_reset = (hold_cnt != '0);

  always_ff @(posedge clk_sys or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      settings <= '0;
      hold_cnt <= '0;
    end else begin
      if (hold_cnt != '0) begin
        hold_cnt <= hold_cnt - 1'b1;
      end

      if (bridge.wr) begin
        case (bridge.addr)
          reg_reset_addr: begin
            hold_cnt <= reset_cnt_w'(reset_hold_cycles);
          end
          reg_mapper_addr: begin
            settings.mapper_sel <= wr_word.fields.sel;
            hold_cnt            <= reset_cnt_w'(reset_hold_cycles);
          end
          reg_sys_type_addr: begin
            settings.sys_type <= wr_word.fields.sel[1:0];
            hold_cnt          <= reset_cnt_w'(reset_hold_cycles);
          end
          // single-bit flags
          reg_ff_snd_addr: begin
            settings.ff_snd_en <= wr_word.fields.sel[0];
          end
          reg_gray_addr: begin
            settings.gray_en <= wr_word.fields.sel[0];
          end
          default: begin
            settings <= settings;
          end
        endcase
      end
    end
  end

endmodule

// ==== hdl/fast_forward_ctrl.sv ====
/*
  Fast-forward control from the r1 key of controller 1, ignored while loading.
  A press shorter than ff_tap_cycles toggles a latch; a long hold is momentary.
  Audio is registered once and muted while fast forward is on without sound.
*/
module fast_forward_ctrl (
  input  logic                                clk_sys,
  input  logic                                pll_core_locked,
  input  logic [core_shell_pkg::word_w-1:0]   cont1_key,
  input  logic                                loading,
  input  logic                                ff_snd_en,
  input  core_shell_pkg::stereo_t             audio_in,
  output logic                                fast_forward,
  output core_shell_pkg::stereo_t             audio_out
);

  import core_shell_pkg::*;

  logic                ff_req;
  logic                prev_req;
  logic [ff_cnt_w-1:0] tap_cnt;
  logic                tap_latched;
  logic                ff_latch;
  logic                req_rise;
  logic                req_fall;
  logic                tap_set;

  assign ff_req   = loading ? 1'b0 : cont1_key[ff_key_bit];
  assign req_rise = ff_req & ~prev_req;
  assign req_fall = ~ff_req & prev_req;

  // short release that should latch, unless the last tap already did
  assign tap_set = req_fall & (tap_cnt < ff_cnt_w'(ff_tap_cycles)) & ~tap_latched;

  ////////////////////////////////
  // tap latch
  ////////////////////////////////
  always_ff @(posedge clk_sys or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      prev_req     <= 1'b0;
      tap_cnt      <= '0;
      tap_latched  <= 1'b0;
      ff_latch     <= 1'b0;
      fast_forward <= 1'b0;
    end else begin
      prev_req <= ff_req;

      if (req_rise) begin
        // new press clears the latch, count starts at one held cycle
        ff_latch <= 1'b0;
        tap_cnt  <= ff_cnt_w'(1);
      end else if (ff_req && tap_cnt < ff_cnt_w'(ff_tap_cycles)) begin
        tap_cnt <= tap_cnt + 1'b1;
      end

      if (req_fall) begin
        tap_latched <= tap_set;
      end
      if (tap_set) begin
        ff_latch <= 1'b1;
      end

      // tap_set covers the release cycle so the output has no gap
      fast_forward <= ff_req | ff_latch | tap_set;
    end
  end

  ////////////////////////////////
  // audio mute
  ////////////////////////////////
  always_ff @(posedge clk_sys or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      audio_out <= '0;
    end else if (fast_forward && !ff_snd_en) begin
      audio_out <= '0;
    end else begin
      audio_out <= audio_in;
    end
  end

endmodule

// ==== hdl/video_out_shaper.sv ====
/*
  Scaler-side video shaping, one pixel per clk_sys cycle.
  de follows the blanking inputs with one cycle of latency; vs becomes a
  one-cycle pulse and hs a one-cycle pulse delayed by hsync_delay cycles.
  Grayscale is applied after the output register, with no extra latency.
*/
module video_out_shaper (
  input  logic                       clk_sys,
  input  logic                       pll_core_locked,
  input  logic                       gray_en,
  input  core_shell_pkg::video_in_t  video_in,
  output core_shell_pkg::video_out_t video_out
);

  import core_shell_pkg::*;

  logic                active;
  logic                hs_prev;
  logic                vs_prev;
  logic [hs_cnt_w-1:0] hs_cnt;
  video_out_t          shaped_q;
  logic [color_w-1:0]  luma;

  assign active = ~(video_in.hblank | video_in.vblank);

  ////////////////////////////////
  // registered pixel and syncs
  ////////////////////////////////
  always_ff @(posedge clk_sys or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      shaped_q <= '0;
      hs_prev  <= 1'b0;
      vs_prev  <= 1'b0;
      hs_cnt   <= '0;
    end else begin
      shaped_q.de <= active;

      // blanked pixels go out black
      if (active) begin
        shaped_q.rgb <= video_in.rgb;
      end else begin
        shaped_q.rgb <= '0;
      end

      // vsync reduced to its rising edge
      shaped_q.vs <= video_in.vs & ~vs_prev;
      vs_prev     <= video_in.vs;

      // hsync pulse fires as the delay count passes one
      shaped_q.hs <= (hs_cnt == hs_cnt_w'(1));
      if (video_in.hs && !hs_prev) begin
        hs_cnt <= hs_cnt_w'(hsync_delay);
      end else if (hs_cnt != '0) begin
        hs_cnt <= hs_cnt - 1'b1;
      end
      hs_prev <= video_in.hs;
    end
  end

  ////////////////////////////////
  // grayscale
  ////////////////////////////////
  // approx 0.28 r + 0.56 g + 0.09 b, each term truncated, sum wraps to 8 bits
  assign luma = (shaped_q.rgb.red >> 2) + (shaped_q.rgb.red >> 5)
              + (shaped_q.rgb.green >> 1) + (shaped_q.rgb.green >> 4)
              + (shaped_q.rgb.blue >> 4) + (shaped_q.rgb.blue >> 5);

  always_comb begin
    video_out = shaped_q;
    if (gray_en) begin
      video_out.rgb.red   = luma;
      video_out.rgb.green = luma;
      video_out.rgb.blue  = luma;
    end
  end

endmodule

// ==== hdl/core_shell.sv ====
/*
  Top level of the console glue logic, all on clk_sys.
  settings carries mapper and system type out to the emulation core.
*/
module core_shell (
  input  logic                              clk_sys,
  input  logic                              pll_core_locked,
  input  core_shell_pkg::bridge_wr_t        bridge,
  input  logic [core_shell_pkg::word_w-1:0] cont1_key,
  input  logic                              loading,
  input  core_shell_pkg::stereo_t           audio_in,
  input  core_shell_pkg::video_in_t         video_in,
  output core_shell_pkg::core_settings_t    settings,
  output logic                              core_reset,
  output logic                              fast_forward,
  output core_shell_pkg::stereo_t           audio_out,
  output core_shell_pkg::video_out_t        video_out
);

  host_settings host_settings_i (
    .clk_sys         (clk_sys),
    .pll_core_locked (pll_core_locked),
    .bridge          (bridge),
    .settings        (settings),
    .core_reset      (core_reset)
  );

  // audio mute needs the fast-forward sound flag
  fast_forward_ctrl fast_forward_ctrl_i (
    .clk_sys         (clk_sys),
    .pll_core_locked (pll_core_locked),
    .cont1_key       (cont1_key),
    .loading         (loading),
    .ff_snd_en       (settings.ff_snd_en),
    .audio_in        (audio_in),
    .fast_forward    (fast_forward),
    .audio_out       (audio_out)
  );

  video_out_shaper video_out_shaper_i (
    .clk_sys         (clk_sys),
    .pll_core_locked (pll_core_locked),
    .gray_en         (settings.gray_en),
    .video_in        (video_in),
    .video_out       (video_out)
  );

endmodule

// ==== verification/core_shell_properties.sv ====
/*
  Concurrent checks on the video and audio outputs, bound into the shaper and
  the fast-forward block. Ports that do not apply to an instance are tied off
  at the bind so that their property is vacuous there.
*/
module core_shell_properties (
  input logic                       clk_sys,
  input logic                       pll_core_locked,
  input core_shell_pkg::video_out_t video_out,
  input logic                       fast_forward,
  input logic                       ff_snd_en,
  input core_shell_pkg::stereo_t    audio_out
);

  timeunit 1ns;
  timeprecision 100ps;

  // vsync leaves as a single-cycle pulse
  vs_single_cycle: assert property (
    @(posedge clk_sys) disable iff (!pll_core_locked) video_out.vs |=> !video_out.vs
  ) else $error("video_out.vs high for two cycles in a row");

  // no colour outside the active area
  rgb_black_when_blank: assert property (
    @(posedge clk_sys) disable iff (!pll_core_locked) !video_out.de |-> (video_out.rgb == '0)
  ) else $error("video_out.rgb non-zero while de is low");

  // muted one cycle after fast forward without sound
  audio_muted: assert property (
    @(posedge clk_sys) disable iff (!pll_core_locked)
      (fast_forward && !ff_snd_en) |=> (audio_out == '0)
  ) else $error("audio_out not zero while fast forward mutes it");

endmodule

// ==== verification/tb_core_shell.sv ====
/*
  Directed testbench for core_shell. Inputs change 2 ns after the rising edge
  and outputs are checked in the same step; no output depends combinationally
  on an input, so checks never race the drive. Video stimulus keeps hsync
  rises more than hsync_delay cycles apart.
*/
module tb_core_shell;

  timeunit 1ns;
  timeprecision 100ps;

  import core_shell_pkg::*;

  localparam int clk_period   = 40;
  localparam int drive_delay  = 2;
  localparam int video_cycles = 200;
  localparam int gray_cycles  = 50;
  // reset, register writes, three reset pulses, ff tests, video, grayscale
  localparam int test_cycles  = 8 + 20 + 3 * (reset_hold_cycles + 2)
                              + 2 * (ff_tap_cycles + 60) + 60 + video_cycles + gray_cycles;

  logic           clk_sys;
  logic           pll_core_locked;
  bridge_wr_t     bridge;
  logic [word_w-1:0] cont1_key;
  logic           loading;
  stereo_t        audio_in;
  video_in_t      video_in;
  core_settings_t settings;
  logic           core_reset;
  logic           fast_forward;
  stereo_t        audio_out;
  video_out_t     video_out;

  core_settings_t exp_set;
  logic [31:0]    lfsr;
  int             err_cnt;
  int             check_cnt;

  core_shell core_shell_i (
    .clk_sys         (clk_sys),
    .pll_core_locked (pll_core_locked),
    .bridge          (bridge),
    .cont1_key       (cont1_key),
    .loading         (loading),
    .audio_in        (audio_in),
    .video_in        (video_in),
    .settings        (settings),
    .core_reset      (core_reset),
    .fast_forward    (fast_forward),
    .audio_out       (audio_out),
    .video_out       (video_out)
  );

  bind fast_forward_ctrl core_shell_properties ff_props_i (
    .clk_sys, .pll_core_locked, .video_out('0), .fast_forward, .ff_snd_en, .audio_out
  );
  bind video_out_shaper core_shell_properties video_props_i (
    .clk_sys, .pll_core_locked, .video_out, .fast_forward(1'b0), .ff_snd_en(1'b1),
    .audio_out('0)
  );

  initial begin
    clk_sys = 1'b0;
    forever #(clk_period / 2) clk_sys = ~clk_sys;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////
  task automatic tick;
    @(posedge clk_sys);
    #drive_delay;
  endtask

  // taps x^32 + x^22 + x^2 + x + 1 with one step per bit
  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // weights 9/32 r, 9/16 g, 3/32 b with every term rounded down
  function automatic logic [color_w-1:0] luma(input rgb_t p);
    int sum;
    sum = p.red / 4 + p.red / 32 + p.green / 2 + p.green / 16 + p.blue / 16 + p.blue / 32;
    return color_w'(sum % 256);
  endfunction

  task automatic write_reg(input logic [word_w-1:0] addr, input logic [word_w-1:0] data);
    bridge.wr   = 1'b1;
    bridge.addr = addr;
    bridge.data = data;
    tick();
    bridge = '0;
  endtask

  // key held for len cycles with fast_forward expected high throughout
  task automatic press_key(input int len);
    cont1_key[ff_key_bit] = 1'b1;
    for (int i = 0; i < len; i++) begin
      tick();
      check_bit("fast_forward", fast_forward, 1'b1);
    end
    cont1_key[ff_key_bit] = 1'b0;
    tick();
  endtask

  task automatic stream_audio(input int n, input logic ff_exp, input logic muted);
    stereo_t smp;
    stereo_t exp;
    for (int i = 0; i < n; i++) begin
      smp = next_bits(2 * sample_w);
      audio_in = smp;
      tick();
      exp = muted ? stereo_t'('0) : smp;
      check_bit("fast_forward", fast_forward, ff_exp);
      check_stereo("audio_out", audio_out, exp);
    end
  endtask

  //////////////////////////////
  // compare tasks
  //////////////////////////////
  task automatic check_settings(input string name, input core_settings_t got,
                                input core_settings_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("FAIL %0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("FAIL %0t %s: got %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_stereo(input string name, input stereo_t got, input stereo_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("FAIL %0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_video_out(input string name, input video_out_t got,
                                 input video_out_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("FAIL %0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////
  task automatic settings_decode;
    // upper data bits set to show that only the select field counts
    write_reg(reg_mapper_addr, 32'habcd_0005);
    exp_set.mapper_sel = 3'd5;
    check_settings("settings", settings, exp_set);
    write_reg(reg_sys_type_addr, 32'hffff_fff6);
    exp_set.sys_type = 2'd2;
    check_settings("settings", settings, exp_set);
    write_reg(reg_ff_snd_addr, 32'h0000_0001);
    exp_set.ff_snd_en = 1'b1;
    check_settings("settings", settings, exp_set);
    write_reg(reg_gray_addr, 32'h0000_0003);
    exp_set.gray_en = 1'b1;
    check_settings("settings", settings, exp_set);
    write_reg(reg_ff_snd_addr, 32'h0000_0000);
    write_reg(reg_gray_addr, 32'h0000_0000);
    exp_set.ff_snd_en = 1'b0;
    exp_set.gray_en   = 1'b0;
    check_settings("settings", settings, exp_set);
    // unmapped addresses with data that would alter every field
    write_reg(32'h0000_0204, 32'h0000_0007);
    check_settings("settings", settings, exp_set);
    write_reg(32'h0000_0000, 32'hffff_ffff);
    check_settings("settings", settings, exp_set);
  endtask

  task automatic reset_pulse;
    logic [word_w-1:0] addrs [3];
    logic [word_w-1:0] data;
    addrs = '{reg_reset_addr, reg_mapper_addr, reg_sys_type_addr};
    for (int a = 0; a < 3; a++) begin
      // rewrite current values so settings hold still
      data = (a == 1) ? word_w'(exp_set.mapper_sel) : word_w'(exp_set.sys_type);
      write_reg(addrs[a], data);
      for (int i = 0; i < reset_hold_cycles; i++) begin
        check_bit("core_reset", core_reset, 1'b1);
        tick();
      end
      check_bit("core_reset", core_reset, 1'b0);
      check_settings("settings", settings, exp_set);
    end
  endtask

  task automatic ff_hold;
    logic [word_w-1:0] keys;
    keys = next_bits(word_w);
    keys[ff_key_bit] = 1'b0;
    cont1_key = keys;
    repeat (2) tick();
    check_bit("fast_forward", fast_forward, 1'b0);
    press_key(ff_tap_cycles + 20);
    repeat (3) tick();
    check_bit("fast_forward", fast_forward, 1'b0);
    // loading masks the key
    loading = 1'b1;
    tick();
    cont1_key[ff_key_bit] = 1'b1;
    for (int i = 0; i < 20; i++) begin
      tick();
      check_bit("fast_forward", fast_forward, 1'b0);
    end
    cont1_key = '0;
    tick();
    loading = 1'b0;
    tick();
    check_bit("fast_forward", fast_forward, 1'b0);
  endtask

  task automatic ff_tap;
    press_key(5);
    stream_audio(10, 1'b1, 1'b1);
    write_reg(reg_ff_snd_addr, 32'h0000_0001);
    exp_set.ff_snd_en = 1'b1;
    check_settings("settings", settings, exp_set);
    stream_audio(10, 1'b1, 1'b0);
    // second tap releases the latch
    press_key(5);
    repeat (3) tick();
    stream_audio(10, 1'b0, 1'b0);
    write_reg(reg_ff_snd_addr, 32'h0000_0000);
    exp_set.ff_snd_en = 1'b0;
    stream_audio(10, 1'b0, 1'b0);
  endtask

  // 20-cycle lines, 100-cycle frames, hs in the line blank, vs in the frame blank
  task automatic video_timing;
    video_in_t   pix;
    video_in_t   prev;
    video_out_t  exp;
    logic [31:0] r;
    int          rise_edge;
    rise_edge = -100;
    for (int c = 0; c < video_cycles; c++) begin
      prev = video_in;
      r = next_bits(3 * color_w);
      pix.rgb    = r[3*color_w-1:0];
      pix.hblank = (c % 20) >= 16;
      pix.vblank = (c % 100) >= 90;
      pix.hs     = (c % 20) == 16 || (c % 20) == 17;
      pix.vs     = (c % 100) >= 90 && (c % 100) < 93;
      video_in = pix;
      if (pix.hs && !prev.hs) begin
        rise_edge = c;
      end
      tick();
      exp.de  = !(pix.hblank || pix.vblank);
      exp.rgb = exp.de ? pix.rgb : '0;
      exp.vs  = pix.vs && !prev.vs;
      exp.hs  = (c == rise_edge + hsync_delay);
      check_video_out("video_out", video_out, exp);
    end
  endtask

  task automatic gray_conversion;
    video_in_t   pix;
    video_out_t  exp;
    logic [31:0] r;
    logic [color_w-1:0] y;
    write_reg(reg_gray_addr, 32'h0000_0001);
    exp_set.gray_en = 1'b1;
    check_settings("settings", settings, exp_set);
    // let any pending hsync pulse drain
    video_in = '0;
    repeat (hsync_delay + 1) tick();
    for (int i = 0; i < gray_cycles; i++) begin
      r = next_bits(3 * color_w);
      pix = '0;
      pix.rgb = r[3*color_w-1:0];
      video_in = pix;
      tick();
      y = luma(pix.rgb);
      exp = '0;
      exp.de = 1'b1;
      exp.rgb.red   = y;
      exp.rgb.green = y;
      exp.rgb.blue  = y;
      check_video_out("video_out", video_out, exp);
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////
  initial begin
    pll_core_locked = 1'b0;
    bridge    = '0;
    cont1_key = '0;
    loading   = 1'b0;
    audio_in  = '0;
    video_in  = '0;
    lfsr      = 32'h89a81136;
    exp_set   = '0;
    err_cnt   = 0;
    check_cnt = 0;
    repeat (8) @(posedge clk_sys);
    #drive_delay;
    check_settings("settings", settings, '0);
    check_bit("core_reset", core_reset, 1'b0);
    check_bit("fast_forward", fast_forward, 1'b0);
    check_stereo("audio_out", audio_out, '0);
    check_video_out("video_out", video_out, '0);
    pll_core_locked = 1'b1;
    tick();
    settings_decode();
    reset_pulse();
    ff_hold();
    ff_tap();
    video_timing();
    gray_conversion();
    $display("checks run: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(clk_period * (test_cycles + 100));
    $display("timeout: tests did not finish within %0d cycles", test_cycles + 100);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// ==== vlog.f ====
hdl/core_shell_pkg.sv
hdl/host_settings.sv
hdl/fast_forward_ctrl.sv
hdl/video_out_shaper.sv
hdl/core_shell.sv
verification/core_shell_properties.sv
verification/tb_core_shell.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_core_shell
RTL_TOP    := core_shell
FILELIST   := vlog.f
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := *** TEST FAILED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation reported a failure, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
